// File: Makefile
SIM = obj_dir/coreSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f core.f --top-module coreTests -o coreSim

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: common/corePkg.sv
package corePkg;

	// Datapath sizes
	localparam int DATA_WIDTH    = 16;
	localparam int REG_COUNT     = 8;
	localparam int REG_SEL_WIDTH = 3;

	// Instruction groups, bits 15..14 in every view
	localparam logic [1:0] GROUP_ARITHMETIC_LOGIC = 2'd0;
	localparam logic [1:0] GROUP_LOAD_STORE       = 2'd1;

	// ALU operation field
	localparam logic [3:0] ALU_OPX_MOV = 4'd0;
	localparam logic [3:0] ALU_OPX_ADD = 4'd1;
	localparam logic [3:0] ALU_OPX_SUB = 4'd2;
	localparam logic [3:0] ALU_OPX_AND = 4'd3;
	localparam logic [3:0] ALU_OPX_OR  = 4'd4;
	localparam logic [3:0] ALU_OPX_XOR = 4'd5;

	// ALU operand modes
	localparam logic [1:0] MODE_REGA_U8   = 2'd0;
	localparam logic [1:0] MODE_REGB_U8   = 2'd1;
	localparam logic [1:0] MODE_REGA_U8RB = 2'd2;
	localparam logic [1:0] MODE_REGA_REGB = 2'd3;

	// Load-store address post-update
	localparam logic [1:0] LDSF_NONE     = 2'd0;
	localparam logic [1:0] LDSF_POST_INC = 2'd1;
	localparam logic [1:0] LDSF_POST_DEC = 2'd2;

	// Load-store direction and mode
	localparam logic LDS_LD       = 1'b0;
	localparam logic LDS_ST       = 1'b1;
	localparam logic MODE_REG_MEM = 1'b1;

	// Named registers
	localparam logic [REG_SEL_WIDTH-1:0] REG_RA = 3'd0;
	localparam logic [REG_SEL_WIDTH-1:0] REG_RB = 3'd1;

	typedef struct packed {
		logic [1:0] group;
		logic [3:0] opx;
		logic [1:0] mode;
		logic [7:0] imm8;
	} aluFields;

	// Reserved pairs pad the load-store view to a full word
	typedef struct packed {
		logic [1:0]               group;
		logic [1:0]               flags;
		logic                     ldSt;
		logic                     mode;
		logic [1:0]               reservedHi;
		logic [REG_SEL_WIDTH-1:0] dataReg;
		logic [1:0]               reservedLo;
		logic [REG_SEL_WIDTH-1:0] addrReg;
	} ldsFields;

	// One instruction word, two readings
	typedef union packed {
		aluFields aluView;
		ldsFields ldsView;
	} instrWord;

	typedef enum logic [1:0] {
		PH_FETCH,
		PH_DECODE,
		PH_EXECUTE,
		PH_COMMIT
	} phaseState;

	typedef enum logic [2:0] {
		ALU_MOV,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} aluOp;

endpackage

// File: core.f
common/corePkg.sv
verilog/phaseSequencer.sv
verilog/programCounter.sv
datapath/instructionDecoder.sv
datapath/registerFile.sv
datapath/aluUnit.sv
verilog/core.sv
test/clockGen.sv
test/coreTests.sv

// File: datapath/aluUnit.sv
`timescale 1ns/10ps

module aluUnit
	import corePkg::*;
(
	input  aluOp                  aluOperation,
	input  logic [1:0]            operandMode,
	input  logic [7:0]            imm8,
	input  logic [DATA_WIDTH-1:0] readDataA,
	input  logic [DATA_WIDTH-1:0] readDataB,
	output logic [DATA_WIDTH-1:0] result
);

	logic [DATA_WIDTH-1:0] firstIn;
	logic [DATA_WIDTH-1:0] operand;

	// RB is the accumulator only in the RB immediate mode
	assign firstIn = (operandMode == MODE_REGB_U8) ? readDataB : readDataA;

	always_comb begin
		case (operandMode)
			MODE_REGA_U8:   operand = {8'h00, imm8};
			MODE_REGB_U8:   operand = {8'h00, imm8};
			// Immediate high, RB low byte
			MODE_REGA_U8RB: operand = {imm8, readDataB[7:0]};
			MODE_REGA_REGB: operand = readDataB;
			default:        operand = readDataB;
		endcase
	end

	// Sums wrap at 16 bits
	always_comb begin
		case (aluOperation)
			ALU_MOV: result = operand;
			ALU_ADD: result = firstIn + operand;
			ALU_SUB: result = firstIn - operand;
			ALU_AND: result = firstIn & operand;
			ALU_OR:  result = firstIn | operand;
			ALU_XOR: result = firstIn ^ operand;
			default: result = operand;
		endcase
	end

endmodule

// File: datapath/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder
	import corePkg::*;
(
	input  logic                     CLK,
	input  logic                     arstN,
	input  logic                     fetch,
	input  logic                     execute,
	input  logic [DATA_WIDTH-1:0]    dbusIn,
	output logic [REG_SEL_WIDTH-1:0] readSelA,
	output logic [REG_SEL_WIDTH-1:0] readSelB,
	output logic [REG_SEL_WIDTH-1:0] writeSel,
	output logic [REG_SEL_WIDTH-1:0] addrSel,
	output aluOp                     aluOperation,
	output logic [1:0]               operandMode,
	output logic [7:0]               imm8,
	output logic                     memRead,
	output logic                     memWrite,
	output logic                     regWriteEn,
	output logic                     addrUpdateEn,
	output logic                     addrStep,
	output logic [DATA_WIDTH-1:0]    loadData,
	output logic                     loadSelect
);

	instrWord instr;
	logic     isLoad;
	logic     isStore;

	// Instruction register, loaded as fetch ends
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			instr <= '0;
		end else if (fetch) begin
			instr <= dbusIn;
		end
	end

	// Load data sampled as LD execute ends
	always_ff @(posedge CLK) begin
		if (execute && isLoad) begin
			loadData <= dbusIn;
		end
	end

	always_comb begin
		readSelA     = REG_RA;
		readSelB     = REG_RB;
		writeSel     = REG_RA;
		addrSel      = instr.ldsView.addrReg;
		aluOperation = ALU_MOV;
		operandMode  = instr.aluView.mode;
		imm8         = instr.aluView.imm8;
		regWriteEn   = 1'b0;
		addrUpdateEn = 1'b0;
		addrStep     = 1'b0;
		isLoad       = 1'b0;
		isStore      = 1'b0;
		case (instr.aluView.group)
			GROUP_ARITHMETIC_LOGIC: begin
				// Only the RB immediate mode targets RB
				if (instr.aluView.mode == MODE_REGB_U8) begin
					writeSel = REG_RB;
				end
				regWriteEn = 1'b1;
				case (instr.aluView.opx)
					ALU_OPX_ADD: aluOperation = ALU_ADD;
					ALU_OPX_SUB: aluOperation = ALU_SUB;
					ALU_OPX_AND: aluOperation = ALU_AND;
					ALU_OPX_OR:  aluOperation = ALU_OR;
					ALU_OPX_XOR: aluOperation = ALU_XOR;
					ALU_OPX_MOV: aluOperation = ALU_MOV;
					default:     aluOperation = ALU_MOV;
				endcase
			end
			GROUP_LOAD_STORE: begin
				if (instr.ldsView.mode == MODE_REG_MEM) begin
					// Port A carries the address, port B the data
					readSelA   = instr.ldsView.addrReg;
					readSelB   = instr.ldsView.dataReg;
					writeSel   = instr.ldsView.dataReg;
					isLoad     = (instr.ldsView.ldSt == LDS_LD);
					isStore    = (instr.ldsView.ldSt == LDS_ST);
					regWriteEn = isLoad;
					case (instr.ldsView.flags)
						LDSF_NONE:     addrUpdateEn = 1'b0;
						LDSF_POST_INC: addrUpdateEn = 1'b1;
						LDSF_POST_DEC: begin
							addrUpdateEn = 1'b1;
							addrStep     = 1'b1;
						end
						default:       addrUpdateEn = 1'b0;
					endcase
				end
			end
			// Other groups fall through as no-ops
			default: ;
		endcase
	end

	// Strobes only live during execute
	assign memRead    = execute & isLoad;
	assign memWrite   = execute & isStore;
	assign loadSelect = isLoad;

endmodule

// File: datapath/registerFile.sv
`timescale 1ns/10ps

module registerFile
	import corePkg::*;
(
	input  logic                     CLK,
	input  logic                     arstN,
	input  logic                     commit,
	input  logic                     regWriteEn,
	input  logic                     addrUpdateEn,
	input  logic                     addrStep,
	input  logic [REG_SEL_WIDTH-1:0] readSelA,
	input  logic [REG_SEL_WIDTH-1:0] readSelB,
	input  logic [REG_SEL_WIDTH-1:0] writeSel,
	input  logic [REG_SEL_WIDTH-1:0] addrSel,
	input  logic [DATA_WIDTH-1:0]    writeData,
	output logic [DATA_WIDTH-1:0]    readDataA,
	output logic [DATA_WIDTH-1:0]    readDataB
);

	logic [DATA_WIDTH-1:0] regs [REG_COUNT];
	logic [DATA_WIDTH-1:0] addrNext;

	// Post-increment or post-decrement by one
	assign addrNext = addrStep ? regs[addrSel] - 16'd1 : regs[addrSel] + 16'd1;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (commit) begin
			if (addrUpdateEn) begin
				regs[addrSel] <= addrNext;
			end
			// Later assignment, so the data write wins a clash
			if (regWriteEn) begin
				regs[writeSel] <= writeData;
			end
		end
	end

	// Asynchronous read ports
	assign readDataA = regs[readSelA];
	assign readDataB = regs[readSelB];

endmodule

// File: test/clockGen.sv
`timescale 1ns/10ps

module clockGen (
	output logic CLK,
	output logic arstN
);

	// 20 ns period
	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	// Reset held for 16 cycles, released just after an edge
	initial begin
		arstN = 1'b0;
		repeat (16) @(posedge CLK);
		#2;
		arstN = 1'b1;
	end

endmodule

// File: test/coreTests.sv
`timescale 1ns/10ps

module coreTests
	import corePkg::*;
();

	localparam int MAX_ROWS = 160;

	logic        CLK;
	logic        arstN;
	logic [15:0] dbusIn;
	logic [15:0] abus;
	logic [15:0] dbusOut;
	logic        rd;
	logic        wr;
	logic        fetch;
	logic        decode;
	logic        execute;
	logic        commit;

	// Stimulus table and expected execute-phase values
	logic [15:0] rowInstr [MAX_ROWS];
	logic [15:0] rowLoad [MAX_ROWS];
	logic        rowRd [MAX_ROWS];
	logic        rowWr [MAX_ROWS];
	logic [15:0] rowAbus [MAX_ROWS];
	logic        rowAbusValid [MAX_ROWS];
	logic [15:0] rowDout [MAX_ROWS];
	logic        rowDoutValid [MAX_ROWS];
	int          rowCount = 0;

	// Register file model
	logic [15:0] modelRegs [8];
	logic [15:0] lastOut = '0;
	logic        haveOut = 1'b0;

	int errorCount = 0;
	int checkCount = 0;
	int cycles = 0;
	int cycleLimit = 100000;

	clockGen i_clockGen (.CLK(CLK), .arstN(arstN));

	core i_dut (
		.CLK(CLK), .arstN(arstN), .dbusIn(dbusIn), .abus(abus), .dbusOut(dbusOut),
		.rd(rd), .wr(wr), .fetch(fetch), .decode(decode), .execute(execute), .commit(commit)
	);

	function automatic logic [15:0] aluInstr(input logic [3:0] opx, input logic [1:0] mode,
			input logic [7:0] imm);
		return {GROUP_ARITHMETIC_LOGIC, opx, mode, imm};
	endfunction

	function automatic logic [15:0] ldsInstr(input logic ldSt, input logic [1:0] flags,
			input logic [2:0] dataReg, input logic [2:0] addrReg);
		return {GROUP_LOAD_STORE, flags, ldSt, MODE_REG_MEM, 2'b00, dataReg, 2'b00, addrReg};
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		checkCount++;
		if (got !== expected) begin
			errorCount++;
			$display("error %s: got %h expected %h", name, got, expected);
		end
	endtask

	// Appends a row and steps the model through its instruction
	task automatic addRow(input logic [15:0] instr, input logic [15:0] load);
		logic [1:0]  grp;
		logic [1:0]  mode;
		logic        isLd;
		logic        isSt;
		logic [2:0]  dReg;
		logic [2:0]  aReg;
		logic [15:0] addr;
		logic [15:0] first;
		logic [15:0] operand;
		logic [15:0] res;
		grp = instr[15:14];
		mode = instr[9:8];
		isLd = grp == GROUP_LOAD_STORE && instr[10] == MODE_REG_MEM && instr[11] == LDS_LD;
		isSt = grp == GROUP_LOAD_STORE && instr[10] == MODE_REG_MEM && instr[11] == LDS_ST;
		dReg = instr[7:5];
		aReg = instr[2:0];
		addr = modelRegs[aReg];
		rowInstr[rowCount] = instr;
		rowLoad[rowCount] = load;
		rowRd[rowCount] = isLd;
		rowWr[rowCount] = isSt;
		rowAbus[rowCount] = addr;
		rowAbusValid[rowCount] = isLd | isSt;
		if (isSt) begin
			lastOut = modelRegs[dReg];
			haveOut = 1'b1;
		end
		// Bus keeps the last stored word between stores
		rowDout[rowCount] = lastOut;
		rowDoutValid[rowCount] = haveOut;
		if (grp == GROUP_ARITHMETIC_LOGIC) begin
			first = (mode == MODE_REGB_U8) ? modelRegs[REG_RB] : modelRegs[REG_RA];
			case (mode)
				MODE_REGA_U8RB: operand = {instr[7:0], modelRegs[REG_RB][7:0]};
				MODE_REGA_REGB: operand = modelRegs[REG_RB];
				default:        operand = {8'h00, instr[7:0]};
			endcase
			case (instr[13:10])
				ALU_OPX_ADD: res = first + operand;
				ALU_OPX_SUB: res = first - operand;
				ALU_OPX_AND: res = first & operand;
				ALU_OPX_OR:  res = first | operand;
				ALU_OPX_XOR: res = first ^ operand;
				default:     res = operand;
			endcase
			if (mode == MODE_REGB_U8) begin
				modelRegs[REG_RB] = res;
			end else begin
				modelRegs[REG_RA] = res;
			end
		end else if (isLd || isSt) begin
			if (instr[13:12] == LDSF_POST_INC) begin
				modelRegs[aReg] = addr + 16'd1;
			end else if (instr[13:12] == LDSF_POST_DEC) begin
				modelRegs[aReg] = addr - 16'd1;
			end
			// Loaded data overrides the address step
			if (isLd) begin
				modelRegs[dReg] = load;
			end
		end
		rowCount++;
	endtask

	// Random RA and RB through two MOVs
	task automatic seedRegs();
		addRow(aluInstr(ALU_OPX_MOV, MODE_REGB_U8, 8'($urandom())), '0);
		addRow(aluInstr(ALU_OPX_MOV, MODE_REGA_U8RB, 8'($urandom())), '0);
	endtask

	task automatic buildTable();
		logic [3:0] opCodes [6];
		logic [1:0] modeCodes [4];
		opCodes = '{ALU_OPX_MOV, ALU_OPX_ADD, ALU_OPX_SUB, ALU_OPX_AND, ALU_OPX_OR, ALU_OPX_XOR};
		modeCodes = '{MODE_REGA_U8, MODE_REGB_U8, MODE_REGA_U8RB, MODE_REGA_REGB};
		for (int i = 0; i < 8; i++) begin
			modelRegs[i] = '0;
		end
		// MOV pair builds 0xfaaf in RA, then store RB there
		addRow(aluInstr(ALU_OPX_MOV, MODE_REGB_U8, 8'haf), '0);
		addRow(aluInstr(ALU_OPX_MOV, MODE_REGA_U8RB, 8'hfa), '0);
		addRow(aluInstr(ALU_OPX_MOV, MODE_REGB_U8, 8'h55), '0);
		addRow(ldsInstr(LDS_ST, LDSF_NONE, REG_RB, REG_RA), '0);
		// Every operation in every mode, result stored through the other register
		for (int op = 0; op < 6; op++) begin
			for (int m = 0; m < 4; m++) begin
				seedRegs();
				addRow(aluInstr(opCodes[op], modeCodes[m], 8'($urandom())), '0);
				if (modeCodes[m] == MODE_REGB_U8) begin
					addRow(ldsInstr(LDS_ST, LDSF_NONE, REG_RB, REG_RA), '0);
				end else begin
					addRow(ldsInstr(LDS_ST, LDSF_NONE, REG_RA, REG_RB), '0);
				end
			end
		end
		// Post-increment and post-decrement through R2
		addRow(aluInstr(ALU_OPX_MOV, MODE_REGA_U8, 8'h40), '0);
		addRow(ldsInstr(LDS_LD, LDSF_NONE, 3'd2, REG_RA), 16'h1000);
		addRow(ldsInstr(LDS_LD, LDSF_POST_INC, 3'd3, 3'd2), 16'($urandom()));
		addRow(ldsInstr(LDS_ST, LDSF_POST_DEC, 3'd3, 3'd2), '0);
		addRow(ldsInstr(LDS_LD, LDSF_POST_DEC, 3'd4, 3'd2), 16'($urandom()));
		addRow(ldsInstr(LDS_ST, LDSF_NONE, 3'd4, 3'd2), '0);
		// Data register equal to address register
		addRow(ldsInstr(LDS_LD, LDSF_POST_INC, 3'd2, 3'd2), 16'h2222);
		addRow(ldsInstr(LDS_ST, LDSF_NONE, 3'd2, 3'd2), '0);
		// No-op groups and register-register mode
		seedRegs();
		addRow({2'b10, 14'($urandom())}, '0);
		addRow({2'b11, 14'($urandom())}, '0);
		addRow({GROUP_LOAD_STORE, 2'($urandom()), 1'($urandom()), 1'b0, 10'($urandom())}, '0);
		addRow(ldsInstr(LDS_ST, LDSF_NONE, REG_RB, REG_RA), '0);
		addRow(ldsInstr(LDS_ST, LDSF_NONE, REG_RA, REG_RB), '0);
	endtask

	task automatic nextPhase();
		@(posedge CLK);
		#2;
	endtask

	task automatic checkStrobes(input logic [3:0] hot, input logic rdExp, input logic wrExp);
		checkValue("phase", 16'({fetch, decode, execute, commit}), 16'(hot));
		checkValue("rd", 16'(rd), 16'(rdExp));
		checkValue("wr", 16'(wr), 16'(wrExp));
	endtask

	// Run limit from the table length
	always @(posedge CLK) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	initial begin
		int errorsBefore;
		dbusIn = '0;
		void'($urandom(23133));
		buildTable();
		cycleLimit = rowCount * 4 + 16 + 40;
		wait (arstN === 1'b1);
		for (int r = 0; r < rowCount; r++) begin
			errorsBefore = errorCount;
			dbusIn = rowInstr[r];
			@(negedge CLK);
			checkStrobes(4'b1000, 1'b1, 1'b0);
			// One row per instruction, so pc tracks the row index
			checkValue("abus", abus, 16'(r));
			nextPhase();
			@(negedge CLK);
			checkStrobes(4'b0100, 1'b0, 1'b0);
			nextPhase();
			if (rowRd[r]) begin
				dbusIn = rowLoad[r];
			end
			@(negedge CLK);
			checkStrobes(4'b0010, rowRd[r], rowWr[r]);
			if (rowAbusValid[r]) begin
				checkValue("abus", abus, rowAbus[r]);
			end
			if (rowDoutValid[r]) begin
				checkValue("dbusOut", dbusOut, rowDout[r]);
			end
			nextPhase();
			@(negedge CLK);
			checkStrobes(4'b0001, 1'b0, 1'b0);
			nextPhase();
			$display("row %0d instr %h %s", r, rowInstr[r],
				(errorCount == errorsBefore) ? "ok" : "mismatch");
		end
		$display("rows %0d checks %0d errors %0d", rowCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/core.sv
`timescale 1ns/10ps

module core
	import corePkg::*;
(
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic [DATA_WIDTH-1:0] dbusIn,
	output logic [DATA_WIDTH-1:0] abus,
	output logic [DATA_WIDTH-1:0] dbusOut,
	output logic                  rd,
	output logic                  wr,
	output logic                  fetch,
	output logic                  decode,
	output logic                  execute,
	output logic                  commit
);

	logic [DATA_WIDTH-1:0]    pc;
	logic [REG_SEL_WIDTH-1:0] readSelA;
	logic [REG_SEL_WIDTH-1:0] readSelB;
	logic [REG_SEL_WIDTH-1:0] writeSel;
	logic [REG_SEL_WIDTH-1:0] addrSel;
	aluOp                     aluOperation;
	logic [1:0]               operandMode;
	logic [7:0]               imm8;
	logic                     memRead;
	logic                     memWrite;
	logic                     regWriteEn;
	logic                     addrUpdateEn;
	logic                     addrStep;
	logic [DATA_WIDTH-1:0]    loadData;
	logic                     loadSelect;
	logic [DATA_WIDTH-1:0]    readDataA;
	logic [DATA_WIDTH-1:0]    readDataB;
	logic [DATA_WIDTH-1:0]    result;
	logic [DATA_WIDTH-1:0]    writeData;
	logic [DATA_WIDTH-1:0]    dbusHold;

	phaseSequencer i_phaseSequencer (
		.CLK(CLK), .arstN(arstN),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit)
	);

	programCounter i_programCounter (
		.CLK(CLK), .arstN(arstN), .commit(commit), .pc(pc)
	);

	instructionDecoder i_instructionDecoder (
		.CLK(CLK), .arstN(arstN), .fetch(fetch), .execute(execute), .dbusIn(dbusIn),
		.readSelA(readSelA), .readSelB(readSelB), .writeSel(writeSel), .addrSel(addrSel),
		.aluOperation(aluOperation), .operandMode(operandMode), .imm8(imm8),
		.memRead(memRead), .memWrite(memWrite), .regWriteEn(regWriteEn),
		.addrUpdateEn(addrUpdateEn), .addrStep(addrStep),
		.loadData(loadData), .loadSelect(loadSelect)
	);

	registerFile i_registerFile (
		.CLK(CLK), .arstN(arstN), .commit(commit), .regWriteEn(regWriteEn),
		.addrUpdateEn(addrUpdateEn), .addrStep(addrStep),
		.readSelA(readSelA), .readSelB(readSelB), .writeSel(writeSel), .addrSel(addrSel),
		.writeData(writeData), .readDataA(readDataA), .readDataB(readDataB)
	);

	aluUnit i_aluUnit (
		.aluOperation(aluOperation), .operandMode(operandMode), .imm8(imm8),
		.readDataA(readDataA), .readDataB(readDataB), .result(result)
	);

	// Loads commit memory data, everything else the ALU result
	assign writeData = loadSelect ? loadData : result;

	// Fetch addresses by pc, otherwise by the address register
	assign abus = fetch ? pc : readDataA;
	assign rd   = fetch | memRead;
	assign wr   = memWrite;

	// Last stored value stays on the bus
	always_ff @(posedge CLK) begin
		if (memWrite) begin
			dbusHold <= readDataB;
		end
	end

	assign dbusOut = memWrite ? readDataB : dbusHold;

endmodule

// File: verilog/phaseSequencer.sv
`timescale 1ns/10ps

module phaseSequencer
	import corePkg::*;
(
	input  logic CLK,
	input  logic arstN,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	phaseState state;
	phaseState nextState;

	// Fixed rotation, no stalls
	always_comb begin
		case (state)
			PH_FETCH:   nextState = PH_DECODE;
			PH_DECODE:  nextState = PH_EXECUTE;
			PH_EXECUTE: nextState = PH_COMMIT;
			default:    nextState = PH_FETCH;
		endcase
	end

	// Reset lands in fetch
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= PH_FETCH;
		end else begin
			state <= nextState;
		end
	end

	// One-hot phase levels
	always_comb begin
		fetch   = (state == PH_FETCH);
		decode  = (state == PH_DECODE);
		execute = (state == PH_EXECUTE);
		commit  = (state == PH_COMMIT);
	end

endmodule

// File: verilog/programCounter.sv
`timescale 1ns/10ps

module programCounter
	import corePkg::*;
(
	input  logic                  CLK,
	input  logic                  arstN,
	input  logic                  commit,
	output logic [DATA_WIDTH-1:0] pc
);

	logic [DATA_WIDTH-1:0] pcNext;

	// Plain increment, wraps at 16 bits
	assign pcNext = pc + 16'd1;

	// Advance at the edge closing commit
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (commit) begin
			pc <= pcNext;
		end
	end

endmodule
